// File: verilog/daq_pkg.sv
`default_nettype none

package daq_pkg;

    // Register bus and event widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // Bus request as every register block sees it
    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        byte_t wdata;
    } bus_req_t;

    // One select per register block, plus the offset inside the block
    typedef struct packed {
        logic  sys;
        logic  ctrl;
        logic  pulse;
        logic  trig;
        logic  tdc;
        byte_t offset;
    } blk_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        DELAY,
        ACTIVE
    } pulse_state_t;

    // Block base addresses, each block spans 256 bytes
    localparam addr_t SYS_BASE   = 16'h0300;
    localparam addr_t PULSE_BASE = 16'h0400;
    localparam addr_t CTRL_BASE  = 16'h0500;
    localparam addr_t TRIG_BASE  = 16'h0600;
    localparam addr_t TDC_BASE   = 16'h0700;

    localparam byte_t VERSION       = 8'd1;
    localparam byte_t VERSION_MINOR = 8'd0;
    localparam byte_t VERSION_MAJOR = 8'd1;
    localparam byte_t BOARD_ID      = 8'd0;

    // Data identifier carried in bits 31:28 of TDC words
    localparam logic [3:0]  TDC_ID      = 4'h2;
    localparam logic [11:0] TDC_LEN_MAX = 12'd4095;

    localparam int FIFO_DEPTH = 8;
    localparam int N_SOURCES  = 2;

endpackage

`default_nettype wire

// File: verilog/bus_decode.sv
`default_nettype none
`timescale 1ns/1ns

module bus_decode (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  logic              i_bus_rd,
    input  logic              i_bus_wr,
    input  daq_pkg::addr_t    i_bus_add,
    input  daq_pkg::byte_t    i_bus_data,
    output daq_pkg::bus_req_t o_req,
    output daq_pkg::blk_sel_t o_sel,
    input  daq_pkg::byte_t    i_rdata_sys,
    input  daq_pkg::byte_t    i_rdata_ctrl,
    input  daq_pkg::byte_t    i_rdata_pulse,
    input  daq_pkg::byte_t    i_rdata_trig,
    input  daq_pkg::byte_t    i_rdata_tdc,
    output daq_pkg::byte_t    o_bus_data
);
    import daq_pkg::*;

    byte_t rdata;

    assign o_req = '{rd: i_bus_rd, wr: i_bus_wr, addr: i_bus_add, wdata: i_bus_data};

    // Blocks are 256 bytes wide, so the upper address byte picks the block
    assign o_sel.sys    = (i_bus_add[15:8] == SYS_BASE[15:8]);
    assign o_sel.ctrl   = (i_bus_add[15:8] == CTRL_BASE[15:8]);
    assign o_sel.pulse  = (i_bus_add[15:8] == PULSE_BASE[15:8]);
    assign o_sel.trig   = (i_bus_add[15:8] == TRIG_BASE[15:8]);
    assign o_sel.tdc    = (i_bus_add[15:8] == TDC_BASE[15:8]);
    assign o_sel.offset = i_bus_add[7:0];

    // Unmapped addresses fall through to zero
    always_comb begin
        case (1'b1)
            o_sel.sys:   rdata = i_rdata_sys;
            o_sel.ctrl:  rdata = i_rdata_ctrl;
            o_sel.pulse: rdata = i_rdata_pulse;
            o_sel.trig:  rdata = i_rdata_trig;
            o_sel.tdc:   rdata = i_rdata_tdc;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            o_bus_data <= '0;
        end else if (i_bus_rd) begin
            o_bus_data <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/control_regs.sv
`default_nettype none
`timescale 1ns/1ns

module control_regs (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::bus_req_t i_req,
    input  daq_pkg::blk_sel_t i_sel,
    input  logic [3:0]        i_gpio_sense,
    output daq_pkg::byte_t    o_rdata_sys,
    output daq_pkg::byte_t    o_rdata_ctrl,
    output logic [7:0]        o_lemo_mux,
    output logic [2:0]        o_ntc_mux,
    output logic              o_mgt_ref_sel,
    output logic              o_reset_hold
);
    import daq_pkg::*;

    logic       configured;
    // Low control byte keeps only its writable upper nibble
    logic [7:4] ctrl_lo;
    byte_t      ctrl_hi;
    logic       hold;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            configured <= 1'b0;
            ctrl_lo    <= '0;
            ctrl_hi    <= '0;
            hold       <= 1'b0;
        end else if (i_req.wr) begin
            if (i_sel.sys && i_sel.offset == 8'd5) begin
                configured <= i_req.wdata[0];
            end
            if (i_sel.ctrl) begin
                case (i_sel.offset)
                    8'd0:    ctrl_lo <= i_req.wdata[7:4];
                    8'd1:    ctrl_hi <= i_req.wdata;
                    8'd2:    hold <= i_req.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (i_sel.offset)
            8'd0:    o_rdata_sys = VERSION;
            8'd1:    o_rdata_sys = VERSION_MINOR;
            8'd2:    o_rdata_sys = VERSION_MAJOR;
            8'd3:    o_rdata_sys = BOARD_ID;
            8'd4:    o_rdata_sys = {7'd0, configured};
            default: o_rdata_sys = '0;
        endcase
    end

    always_comb begin
        case (i_sel.offset)
            8'd0:    o_rdata_ctrl = {ctrl_lo, i_gpio_sense};
            8'd1:    o_rdata_ctrl = ctrl_hi;
            8'd2:    o_rdata_ctrl = {7'd0, hold};
            default: o_rdata_ctrl = '0;
        endcase
    end

    // LEMO select straddles the two control bytes
    assign o_lemo_mux    = {ctrl_hi[6:0], ctrl_lo[7]};
    assign o_ntc_mux     = ctrl_lo[6:4];
    // Inverted so the cleared register selects the internal reference clock
    assign o_mgt_ref_sel = ~ctrl_hi[7];
    assign o_reset_hold  = hold;

endmodule

`default_nettype wire

// File: verilog/reset_pulser.sv
`default_nettype none
`timescale 1ns/1ns

module reset_pulser (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::bus_req_t i_req,
    input  daq_pkg::blk_sel_t i_sel,
    input  logic              i_reset_hold,
    output daq_pkg::byte_t    o_rdata,
    output logic              o_resetb_ext
);
    import daq_pkg::*;

    pulse_state_t state_q;
    byte_t        delay_q;
    byte_t        width_q;
    byte_t        delay_cnt;
    byte_t        width_cnt;
    logic         hold_d;
    logic         start;

    // Bus start, or the cycle after the hold is released
    assign start = (i_req.wr && i_sel.pulse && i_sel.offset == 8'd0)
                 || (hold_d && !i_reset_hold);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            delay_q <= '0;
            width_q <= '0;
            hold_d  <= 1'b0;
        end else begin
            hold_d <= i_reset_hold;
            if (i_req.wr && i_sel.pulse && i_sel.offset == 8'd1) begin
                delay_q <= i_req.wdata;
            end
            if (i_req.wr && i_sel.pulse && i_sel.offset == 8'd2) begin
                width_q <= i_req.wdata;
            end
        end
    end

    // DELAY lasts delay+1 cycles, ACTIVE exactly width cycles
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state_q   <= IDLE;
            delay_cnt <= '0;
            width_cnt <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q   <= DELAY;
                        delay_cnt <= delay_q;
                    end
                end
                DELAY: begin
                    if (delay_cnt == '0) begin
                        // Zero width skips the pulse entirely
                        state_q   <= (width_q == '0) ? IDLE : ACTIVE;
                        width_cnt <= width_q;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                ACTIVE: begin
                    if (width_cnt == 8'd1) begin
                        state_q <= IDLE;
                    end else begin
                        width_cnt <= width_cnt - 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (i_sel.offset)
            8'd0:    o_rdata = {7'd0, state_q == IDLE};
            8'd1:    o_rdata = delay_q;
            8'd2:    o_rdata = width_q;
            default: o_rdata = '0;
        endcase
    end

    assign o_resetb_ext = !((state_q == ACTIVE) || i_reset_hold);

    a_start_only: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (state_q == IDLE && !start) |=> state_q == IDLE);

endmodule

`default_nettype wire

// File: verilog/trigger_recorder.sv
`default_nettype none
`timescale 1ns/1ns

module trigger_recorder (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::bus_req_t i_req,
    input  daq_pkg::blk_sel_t i_sel,
    input  logic              i_trigger,
    input  logic              i_fifo_full,
    output daq_pkg::byte_t    o_rdata,
    output logic              o_wr,
    output daq_pkg::word_t    o_word
);
    import daq_pkg::*;

    logic        enable;
    logic        trig_d;
    logic [30:0] trig_num;
    logic        accept;

    // Dropped triggers keep their number for the next edge
    assign accept = enable && i_trigger && !trig_d && !i_fifo_full;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            enable   <= 1'b0;
            trig_d   <= 1'b0;
            trig_num <= '0;
            o_wr     <= 1'b0;
        end else begin
            trig_d <= i_trigger;
            o_wr   <= accept;
            if (i_req.wr && i_sel.trig && i_sel.offset == 8'd0) begin
                enable <= i_req.wdata[0];
            end
            if (accept) begin
                trig_num <= trig_num + 1'b1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (accept) begin
            o_word <= {1'b1, trig_num};
        end
    end

    assign o_rdata = (i_sel.offset == 8'd0) ? {7'd0, enable} : '0;

endmodule

`default_nettype wire

// File: verilog/hitor_tdc.sv
`default_nettype none
`timescale 1ns/1ns

module hitor_tdc (
    input  logic              BUS_CLK,
    input  logic              BUS_RST,
    input  daq_pkg::bus_req_t i_req,
    input  daq_pkg::blk_sel_t i_sel,
    input  logic              i_hitor,
    input  logic              i_fifo_full,
    output daq_pkg::byte_t    o_rdata,
    output logic              o_wr,
    output daq_pkg::word_t    o_word
);
    import daq_pkg::*;

    logic        enable;
    logic        hit_d;
    logic [11:0] hit_len;
    logic [15:0] evt_num;
    logic        accept;

    // Word is formed on the falling edge of HITOR
    assign accept = enable && hit_d && !i_hitor && !i_fifo_full;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            enable  <= 1'b0;
            hit_d   <= 1'b0;
            hit_len <= '0;
            evt_num <= '0;
            o_wr    <= 1'b0;
        end else begin
            hit_d <= i_hitor;
            o_wr  <= accept;
            if (i_req.wr && i_sel.tdc && i_sel.offset == 8'd0) begin
                enable <= i_req.wdata[0];
            end
            // Count sampled high cycles, saturating at the limit
            if (i_hitor && !hit_d) begin
                hit_len <= 12'd1;
            end else if (i_hitor && hit_len != TDC_LEN_MAX) begin
                hit_len <= hit_len + 1'b1;
            end
            if (accept) begin
                evt_num <= evt_num + 1'b1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (accept) begin
            o_word <= {TDC_ID, evt_num, hit_len};
        end
    end

    assign o_rdata = (i_sel.offset == 8'd0) ? {7'd0, enable} : '0;

endmodule

`default_nettype wire

// File: verilog/event_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module event_fifo #(
    parameter int DEPTH = daq_pkg::FIFO_DEPTH
) (
    input  logic           BUS_CLK,
    input  logic           BUS_RST,
    input  logic           i_wr,
    input  daq_pkg::word_t i_data,
    input  logic           i_read,
    output daq_pkg::word_t o_data,
    output logic           o_empty,
    output logic           o_full
);
    import daq_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t                    mem [DEPTH];
    logic [AW-1:0]            wr_ptr;
    logic [AW-1:0]            rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                     do_wr;
    logic                     do_rd;

    assign do_wr = i_wr && !o_full;
    assign do_rd = i_read && !o_empty;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Show-ahead output, head word visible while not empty
    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH);

    a_no_overflow: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        i_wr |-> !o_full);
    a_no_underflow: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        i_read |-> !o_empty);

endmodule

`default_nettype wire

// File: verilog/rr_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module rr_arbiter (
    input  logic                          BUS_CLK,
    input  logic                          BUS_RST,
    input  logic [daq_pkg::N_SOURCES-1:0] i_req_valid,
    input  daq_pkg::word_t                i_data_0,
    input  daq_pkg::word_t                i_data_1,
    output logic [daq_pkg::N_SOURCES-1:0] o_read,
    input  logic                          i_arb_ready,
    output logic                          o_arb_write,
    output daq_pkg::word_t                o_arb_data
);
    import daq_pkg::*;

    word_t                          src_data [N_SOURCES];
    logic [N_SOURCES-1:0]           grant;
    logic [$clog2(N_SOURCES)-1:0]   last_q;
    logic [$clog2(N_SOURCES)-1:0]   pick;

    assign src_data[0] = i_data_0;
    assign src_data[1] = i_data_1;

    // Search starts just after the last granted source
    always_comb begin
        int   cand;
        logic found;
        grant = '0;
        pick  = last_q;
        found = 1'b0;
        for (int i = 1; i <= N_SOURCES; i++) begin
            cand = (int'(last_q) + i) % N_SOURCES;
            if (!found && i_req_valid[cand]) begin
                found       = 1'b1;
                grant[cand] = 1'b1;
                pick        = cand[$clog2(N_SOURCES)-1:0];
            end
        end
    end

    // Read and write share a cycle, so back-pressure stops both
    assign o_read      = grant & {N_SOURCES{i_arb_ready}};
    assign o_arb_write = |o_read;
    assign o_arb_data  = src_data[pick];

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            last_q <= '0;
        end else if (o_arb_write) begin
            last_q <= pick;
        end
    end

    a_onehot_read: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        $onehot0(o_read));
    // With every source waiting, the same source is never served twice in a row
    a_rotate: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (o_arb_write && &i_req_valid) |=> !(o_arb_write && &i_req_valid)
            || pick != $past(pick));

endmodule

`default_nettype wire

// File: verilog/daq_top.sv
`default_nettype none
`timescale 1ns/1ns

module daq_top (
    input  logic           BUS_CLK,
    input  logic           BUS_RST,
    input  logic           i_bus_rd,
    input  logic           i_bus_wr,
    input  daq_pkg::addr_t i_bus_add,
    input  daq_pkg::byte_t i_bus_data,
    output daq_pkg::byte_t o_bus_data,
    input  logic [3:0]     i_gpio_sense,
    output logic [7:0]     o_lemo_mux,
    output logic [2:0]     o_ntc_mux,
    output logic           o_mgt_ref_sel,
    output logic           o_resetb_ext,
    input  logic           i_trigger,
    input  logic           i_hitor,
    input  logic           i_arb_ready,
    output logic           o_arb_write,
    output daq_pkg::word_t o_arb_data
);
    import daq_pkg::*;

    bus_req_t req;
    blk_sel_t sel;
    byte_t    rdata_sys;
    byte_t    rdata_ctrl;
    byte_t    rdata_pulse;
    byte_t    rdata_trig;
    byte_t    rdata_tdc;
    logic     reset_hold;

    // Event path, source 0 is the trigger recorder and source 1 the TDC
    logic  trig_wr;
    word_t trig_word;
    logic  trig_full;
    logic  trig_empty;
    logic  trig_read;
    word_t trig_fifo_data;
    logic  tdc_wr;
    word_t tdc_word;
    logic  tdc_full;
    logic  tdc_empty;
    logic  tdc_read;
    word_t tdc_fifo_data;

    bus_decode u_bus_decode (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_bus_rd     (i_bus_rd),
        .i_bus_wr     (i_bus_wr),
        .i_bus_add    (i_bus_add),
        .i_bus_data   (i_bus_data),
        .o_req        (req),
        .o_sel        (sel),
        .i_rdata_sys  (rdata_sys),
        .i_rdata_ctrl (rdata_ctrl),
        .i_rdata_pulse(rdata_pulse),
        .i_rdata_trig (rdata_trig),
        .i_rdata_tdc  (rdata_tdc),
        .o_bus_data   (o_bus_data)
    );

    control_regs u_control_regs (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_req        (req),
        .i_sel        (sel),
        .i_gpio_sense (i_gpio_sense),
        .o_rdata_sys  (rdata_sys),
        .o_rdata_ctrl (rdata_ctrl),
        .o_lemo_mux   (o_lemo_mux),
        .o_ntc_mux    (o_ntc_mux),
        .o_mgt_ref_sel(o_mgt_ref_sel),
        .o_reset_hold (reset_hold)
    );

    reset_pulser u_reset_pulser (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_req       (req),
        .i_sel       (sel),
        .i_reset_hold(reset_hold),
        .o_rdata     (rdata_pulse),
        .o_resetb_ext(o_resetb_ext)
    );

    trigger_recorder u_trigger_recorder (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .i_req      (req),
        .i_sel      (sel),
        .i_trigger  (i_trigger),
        .i_fifo_full(trig_full),
        .o_rdata    (rdata_trig),
        .o_wr       (trig_wr),
        .o_word     (trig_word)
    );

    hitor_tdc u_hitor_tdc (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .i_req      (req),
        .i_sel      (sel),
        .i_hitor    (i_hitor),
        .i_fifo_full(tdc_full),
        .o_rdata    (rdata_tdc),
        .o_wr       (tdc_wr),
        .o_word     (tdc_word)
    );

    event_fifo #(.DEPTH(FIFO_DEPTH)) u_trig_fifo (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .i_wr   (trig_wr),
        .i_data (trig_word),
        .i_read (trig_read),
        .o_data (trig_fifo_data),
        .o_empty(trig_empty),
        .o_full (trig_full)
    );

    event_fifo #(.DEPTH(FIFO_DEPTH)) u_tdc_fifo (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .i_wr   (tdc_wr),
        .i_data (tdc_word),
        .i_read (tdc_read),
        .o_data (tdc_fifo_data),
        .o_empty(tdc_empty),
        .o_full (tdc_full)
    );

    rr_arbiter u_rr_arbiter (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .i_req_valid({~tdc_empty, ~trig_empty}),
        .i_data_0   (trig_fifo_data),
        .i_data_1   (tdc_fifo_data),
        .o_read     ({tdc_read, trig_read}),
        .i_arb_ready(i_arb_ready),
        .o_arb_write(o_arb_write),
        .o_arb_data (o_arb_data)
    );

endmodule

`default_nettype wire

// File: sim/tb_daq_tasks.svh
// Bus access, one strobe cycle per transfer
task automatic bus_write(input addr_t addr, input byte_t data);
    i_bus_wr   = 1'b1;
    i_bus_add  = addr;
    i_bus_data = data;
    step();
    i_bus_wr   = 1'b0;
endtask

task automatic bus_read(input addr_t addr, output byte_t data);
    i_bus_rd  = 1'b1;
    i_bus_add = addr;
    step();
    i_bus_rd  = 1'b0;
    data      = o_bus_data;
endtask

task automatic trigger_pulse();
    i_trigger = 1'b1;
    step();
    i_trigger = 1'b0;
    step();
    step();
endtask

// HITOR high for len cycles, expected length saturates at the TDC limit
task automatic hitor_pulse(input int len);
    i_hitor = 1'b1;
    repeat (len) step();
    i_hitor = 1'b0;
    step();
    step();
    exp_len_q.push_back((len > TDC_LEN_MAX) ? int'(TDC_LEN_MAX) : len);
endtask

task automatic wait_for_words(input int n_trig, input int n_tdc);
    int n;
    n = 0;
    while ((trig_q.size() < n_trig || tdc_q.size() < n_tdc) && n < TIMEOUT_CYCLES) begin
        step();
        n++;
    end
    if (trig_q.size() < n_trig || tdc_q.size() < n_tdc) begin
        report_error($sformatf("timed out waiting for %0d trigger and %0d TDC words",
                               n_trig, n_tdc));
    end
endtask

task automatic check_trig_words(input int n);
    word_t w;
    for (int i = 0; i < n; i++) begin
        if (trig_q.size() == 0) begin
            report_error("a trigger word is missing from the output stream");
            return;
        end
        w = trig_q.pop_front();
        check("o_arb_data trigger word", w, {1'b1, exp_trig_num});
        exp_trig_num++;
    end
endtask

task automatic check_tdc_words();
    word_t       w;
    logic [11:0] len;
    while (exp_len_q.size() > 0) begin
        len = 12'(exp_len_q.pop_front());
        if (tdc_q.size() == 0) begin
            report_error("a TDC word is missing from the output stream");
            return;
        end
        w = tdc_q.pop_front();
        check("o_arb_data TDC word", w, {TDC_ID, exp_tdc_num, len});
        exp_tdc_num++;
    end
endtask

// Nothing more may arrive once the expected words are out
task automatic check_drained();
    repeat (12) step();
    check("extra trigger words", trig_q.size(), 0);
    check("extra TDC words", tdc_q.size(), 0);
    trig_q.delete();
    tdc_q.delete();
endtask

task automatic test_readback();
    byte_t d;
    bus_read(SYS_BASE, d);
    check("sys version", d, VERSION);
    bus_read(SYS_BASE + 16'd1, d);
    check("sys version minor", d, VERSION_MINOR);
    bus_read(SYS_BASE + 16'd2, d);
    check("sys version major", d, VERSION_MAJOR);
    bus_read(SYS_BASE + 16'd3, d);
    check("sys board id", d, BOARD_ID);
    bus_read(SYS_BASE + 16'd4, d);
    check("sys configured flag", d, 0);
    bus_write(SYS_BASE + 16'd5, 8'h01);
    bus_read(SYS_BASE + 16'd4, d);
    check("sys configured flag", d, 1);
    bus_read(16'h0900, d);
    check("unmapped read", d, 0);
endtask

task automatic test_control();
    byte_t d;
    byte_t lo;
    byte_t hi;
    lo = 8'hd5;
    hi = 8'h96;
    check("o_mgt_ref_sel", o_mgt_ref_sel, 1);
    check("o_lemo_mux", o_lemo_mux, 0);
    i_gpio_sense = 4'ha;
    bus_write(CTRL_BASE, lo);
    bus_write(CTRL_BASE + 16'd1, hi);
    check("o_ntc_mux", o_ntc_mux, lo[6:4]);
    check("o_lemo_mux", o_lemo_mux, {hi[6:0], lo[7]});
    check("o_mgt_ref_sel", o_mgt_ref_sel, !hi[7]);
    bus_read(CTRL_BASE, d);
    check("ctrl low byte", d, {lo[7:4], i_gpio_sense});
endtask

task automatic test_reset_pulse();
    byte_t d;
    int    delay;
    int    width;
    int    n;
    delay = lfsr_bits(4);
    width = 1 + lfsr_bits(4);
    bus_write(PULSE_BASE + 16'd1, 8'(delay));
    bus_write(PULSE_BASE + 16'd2, 8'(width));
    bus_write(PULSE_BASE, 8'h01);
    // Low from edge t+1+delay for width cycles
    for (int k = 1; k <= delay + width + 3; k++) begin
        step();
        check("o_resetb_ext", o_resetb_ext, !(k >= delay + 1 && k <= delay + width));
    end
    bus_read(PULSE_BASE, d);
    check("pulse done", d[0], 1);

    bus_write(CTRL_BASE + 16'd2, 8'h01);
    repeat (4) begin
        check("o_resetb_ext during hold", o_resetb_ext, 0);
        step();
    end
    bus_write(CTRL_BASE + 16'd2, 8'h00);
    n = 0;
    while (o_resetb_ext && n < TIMEOUT_CYCLES) begin
        step();
        n++;
    end
    if (o_resetb_ext) begin
        report_error("no reset pulse followed the release of the hold");
        return;
    end
    n = 0;
    while (!o_resetb_ext && n < TIMEOUT_CYCLES) begin
        step();
        n++;
    end
    check("pulse width after hold", n, width);
endtask

task automatic test_triggers();
    i_arb_ready = 1'b1;
    bus_write(TRIG_BASE, 8'h01);
    repeat (5) trigger_pulse();
    wait_for_words(5, 0);
    check_trig_words(5);
    check_drained();

    // FIFO holds 8, the last two edges are dropped
    i_arb_ready = 1'b0;
    repeat (10) trigger_pulse();
    i_arb_ready = 1'b1;
    wait_for_words(8, 0);
    check_trig_words(8);
    check_drained();

    bus_write(TRIG_BASE, 8'h00);
    repeat (3) trigger_pulse();
    check_drained();
endtask

task automatic test_tdc();
    i_arb_ready = 1'b1;
    bus_write(TDC_BASE, 8'h01);
    repeat (5) hitor_pulse(1 + lfsr_bits(6));
    hitor_pulse(4100);
    wait_for_words(0, 6);
    check_tdc_words();
    check_drained();
endtask

task automatic test_merge();
    int len;
    bus_write(TRIG_BASE, 8'h01);
    rand_ready = 1'b1;
    for (int i = 0; i < 8; i++) begin
        len = 1 + lfsr_bits(3);
        i_trigger = 1'b1;
        i_hitor   = (i < 6);
        step();
        i_trigger = 1'b0;
        repeat (len - 1) step();
        i_hitor = 1'b0;
        step();
        step();
        if (i < 6) begin
            exp_len_q.push_back(len);
        end
    end
    wait_for_words(8, 6);
    rand_ready  = 1'b0;
    i_arb_ready = 1'b1;
    check_trig_words(8);
    check_tdc_words();
    check_drained();
endtask

// File: sim/tb_daq_top.sv
`default_nettype none
`timescale 1ns/1ns

module tb_daq_top;
    import daq_pkg::*;

    localparam int DRV_DLY        = 2;
    localparam int TIMEOUT_CYCLES = 400;

    logic       BUS_CLK;
    logic       BUS_RST;
    logic       i_bus_rd;
    logic       i_bus_wr;
    addr_t      i_bus_add;
    byte_t      i_bus_data;
    byte_t      o_bus_data;
    logic [3:0] i_gpio_sense;
    logic [7:0] o_lemo_mux;
    logic [2:0] o_ntc_mux;
    logic       o_mgt_ref_sel;
    logic       o_resetb_ext;
    logic       i_trigger;
    logic       i_hitor;
    logic       i_arb_ready;
    logic       o_arb_write;
    word_t      o_arb_data;

    int          n_checks;
    int          n_errors;
    logic [31:0] lfsr_q;
    // Ready follows the LFSR while set
    logic        rand_ready;

    // Scoreboard queues, split on bit 31 of each output word
    word_t       trig_q [$];
    word_t       tdc_q [$];
    int          exp_len_q [$];
    logic [30:0] exp_trig_num;
    logic [15:0] exp_tdc_num;

    daq_top UUT (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_bus_rd     (i_bus_rd),
        .i_bus_wr     (i_bus_wr),
        .i_bus_add    (i_bus_add),
        .i_bus_data   (i_bus_data),
        .o_bus_data   (o_bus_data),
        .i_gpio_sense (i_gpio_sense),
        .o_lemo_mux   (o_lemo_mux),
        .o_ntc_mux    (o_ntc_mux),
        .o_mgt_ref_sel(o_mgt_ref_sel),
        .o_resetb_ext (o_resetb_ext),
        .i_trigger    (i_trigger),
        .i_hitor      (i_hitor),
        .i_arb_ready  (i_arb_ready),
        .o_arb_write  (o_arb_write),
        .o_arb_data   (o_arb_data)
    );

    always #20 BUS_CLK = ~BUS_CLK;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic int lfsr_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            n_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        n_errors++;
    endtask

    // One clock, inputs change a little after the rising edge
    task automatic step();
        @(posedge BUS_CLK);
        #DRV_DLY;
        if (rand_ready) begin
            i_arb_ready = (lfsr_bits(1) == 1);
        end
    endtask

    // Output words are taken mid-cycle, ahead of the edge that writes them
    always @(negedge BUS_CLK) begin
        if (!BUS_RST && o_arb_write) begin
            if (!i_arb_ready) begin
                report_error("o_arb_write went high while i_arb_ready was low");
            end
            if (o_arb_data[31]) begin
                trig_q.push_back(o_arb_data);
            end else begin
                tdc_q.push_back(o_arb_data);
            end
        end
    end

    `include "tb_daq_tasks.svh"

    initial begin
        BUS_CLK      = 1'b0;
        BUS_RST      = 1'b1;
        i_bus_rd     = 1'b0;
        i_bus_wr     = 1'b0;
        i_bus_add    = '0;
        i_bus_data   = '0;
        i_gpio_sense = '0;
        i_trigger    = 1'b0;
        i_hitor      = 1'b0;
        i_arb_ready  = 1'b0;
        rand_ready   = 1'b0;
        lfsr_q       = 32'd99128;
        n_checks     = 0;
        n_errors     = 0;
        exp_trig_num = '0;
        exp_tdc_num  = '0;

        repeat (8) @(posedge BUS_CLK);
        #DRV_DLY;
        BUS_RST = 1'b0;

        check("o_arb_write", o_arb_write, 0);
        check("o_resetb_ext", o_resetb_ext, 1);

        test_readback();
        test_control();
        test_reset_pulse();
        test_triggers();
        test_tdc();
        test_merge();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+sim
verilog/daq_pkg.sv
verilog/bus_decode.sv
verilog/control_regs.sv
verilog/reset_pulser.sv
verilog/trigger_recorder.sv
verilog/hitor_tdc.sv
verilog/event_fifo.sv
verilog/rr_arbiter.sv
verilog/daq_top.sv
sim/tb_daq_top.sv
